// ==== sources.f ====
+incdir+include
verilog/ddr3_cmd_pkg.sv
verilog/axi_fast_pkg.sv
verilog/bypass_timer.sv
verilog/bypass_fsm.sv
verilog/bypass_cmd_mux.sv
verilog/bypass_read_path.sv
verilog/ddr3_bypass.sv
testbench/ddr3_bypass_chk.sv
testbench/ddr3_bypass_tb.sv

// ==== Makefile ====
# Verilator build for the DDR3 fast-read port testbench

VERILATOR ?= verilator
TOP ?= ddr3_bypass_tb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps
EXTRA_FLAGS ?=

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) $(EXTRA_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulator exit status carries pass or fail
run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== testbench/ddr3_bypass_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr3_bypass_tb;
  import ddr3_cmd_pkg::*;
  import axi_fast_pkg::*;

  localparam int WIDTH = 32;
  // DDR3 spacing in cycles
  localparam int T_RP = 4;
  localparam int T_RCD = 4;
  // each fast read and each controller command counts as one
  localparam int N_TRANS = 9;
  localparam int CYCLE_LIMIT = 200 * N_TRANS;

  // one pending burst in the DDL model
  typedef struct packed {
    logic [2:0] bank;
    logic [12:0] row;
    logic [9:0] col;
  } burst_s;

  logic clock = 1'b0;
  logic reset;
  logic fast_valid_i;
  fast_req_s fast_req_i;
  logic fast_ready_o;
  logic rready_i;
  logic rvalid_o;
  fast_resp_s resp_o;
  logic ctl_req_i;
  ddr_cmd_s ctl_cmd_i;
  logic ctl_ack_o;
  logic ddl_req_o;
  ddr_cmd_s ddl_cmd_o;
  logic ddl_ack_i;
  logic ddl_rvalid_i;
  logic ddl_rlast_i;
  logic [WIDTH-1:0] ddl_rdata_i;
  logic ddl_rready_o;
  logic ctl_rvalid_o;
  logic ctl_rlast_o;
  logic [WIDTH-1:0] ctl_rdata_o;
  logic ctl_rready_i;
  logic fast_err_o;

  integer seed = 32'hc5ac_c128;
  int cycle = 0;
  // command log of the DDL model
  ddr_cmd_s cmd_log[$];
  int req_cyc[$];
  int done_cyc[$];
  int log_n = 0;
  // open bank as seen on the DDL command port
  logic trk_open = 1'b0;
  logic [2:0] trk_bank = '0;
  logic [12:0] trk_row = '0;
  logic [12:0] bank_row[8];
  burst_s burst_q[$];
  fast_resp_s exp_beats[$];
  logic [WIDTH-1:0] exp_ctl[$];
  int beats_seen = 0;
  int ctl_beats_seen = 0;
  int dropped_n = 0;
  int accepted_n = 0;
  int last_beat_cyc = 0;
  int ctl_ack_cyc = 0;

  ddr3_bypass #(
    .WIDTH(WIDTH)
  ) dut_i (
    .clock(clock),
    .reset(reset),
    .fast_valid_i(fast_valid_i),
    .fast_req_i(fast_req_i),
    .fast_ready_o(fast_ready_o),
    .rready_i(rready_i),
    .rvalid_o(rvalid_o),
    .resp_o(resp_o),
    .ctl_req_i(ctl_req_i),
    .ctl_cmd_i(ctl_cmd_i),
    .ctl_ack_o(ctl_ack_o),
    .ddl_req_o(ddl_req_o),
    .ddl_cmd_o(ddl_cmd_o),
    .ddl_ack_i(ddl_ack_i),
    .ddl_rvalid_i(ddl_rvalid_i),
    .ddl_rlast_i(ddl_rlast_i),
    .ddl_rdata_i(ddl_rdata_i),
    .ddl_rready_o(ddl_rready_o),
    .ctl_rvalid_o(ctl_rvalid_o),
    .ctl_rlast_o(ctl_rlast_o),
    .ctl_rdata_o(ctl_rdata_o),
    .ctl_rready_i(ctl_rready_i),
    .fast_err_o(fast_err_o)
  );

  always #5 clock = ~clock;

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  // counted on the falling edge, away from sampling
  always @(negedge clock) begin
    cycle = cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      abort_run($sformatf("timeout: no finish within %0d cycles", CYCLE_LIMIT));
    end
  end

  // data of a DDL beat from its location
  function automatic logic [31:0] beat_data(input logic [2:0] bank, input logic [12:0] row,
                                            input logic [9:0] col, input logic [1:0] beat);
    return {7'h5a, row, bank, col[9:3], beat};
  endfunction

  function automatic ddr_cmd_s make_cmd(input ddr3_cmd_t op, input logic [2:0] bank,
                                        input logic [12:0] addr, input logic ap);
    ddr_cmd_s c;
    c.op = op;
    c.bank = bank;
    c.addr = addr;
    c.auto_pre = ap;
    return c;
  endfunction

  // number of DDL commands a fast read needs
  function automatic int cmds_needed(input logic open, input logic [2:0] obank,
                                     input logic [12:0] orow, input logic [22:0] araddr);
    if (open && obank == araddr[9:7]) begin
      return (orow == araddr[22:10]) ? 1 : 4;
    end
    return 2;
  endfunction

  // expected command k of a fast read
  function automatic ddr_cmd_s expected_cmd(input int k, input logic open,
                                            input logic [2:0] obank,
                                            input logic [12:0] orow,
                                            input logic [22:0] araddr);
    logic [12:0] row;
    logic [2:0] bank;
    logic [12:0] col;
    logic same_bank;
    row = araddr[22:10];
    bank = araddr[9:7];
    col = {3'b000, araddr[6:0], 3'b000};
    same_bank = open && (obank == bank);
    if (same_bank && orow == row) begin
      return make_cmd(READ, bank, col, 1'b0);
    end
    if (same_bank) begin
      case (k)
        0: return make_cmd(PREC, bank, 13'd0, 1'b0);
        1: return make_cmd(ACTV, bank, row, 1'b0);
        2: return make_cmd(READ, bank, col, 1'b1);
        default: return make_cmd(ACTV, bank, orow, 1'b0);
      endcase
    end
    if (k == 0) begin
      return make_cmd(ACTV, bank, row, 1'b0);
    end
    return make_cmd(READ, bank, col, 1'b1);
  endfunction

  // DDL command port, acks after 1 to 3 cycles
  initial begin : ddl_cmd_port
    ddr_cmd_s cmd;
    int delay;
    int rq;
    ddl_ack_i = 1'b0;
    forever begin
      @(posedge clock);
      if (!reset && ddl_req_o && !ddl_ack_i) begin
        cmd = ddl_cmd_o;
        rq = cycle;
        delay = int'($unsigned($random(seed)) % 3);
        repeat (delay) @(posedge clock);
        #1 ddl_ack_i = 1'b1;
        cmd_log.push_back(cmd);
        req_cyc.push_back(rq);
        log_n = log_n + 1;
        case (cmd.op)
          ACTV: begin
            trk_open = 1'b1;
            trk_bank = cmd.bank;
            trk_row = cmd.addr;
            bank_row[cmd.bank] = cmd.addr;
          end
          PREC: trk_open = 1'b0;
          READ: begin
            burst_q.push_back({cmd.bank, bank_row[cmd.bank], cmd.addr[9:0]});
            if (cmd.auto_pre) begin
              trk_open = 1'b0;
            end
          end
          default: ;
        endcase
        do @(posedge clock); while (ddl_req_o);
        done_cyc.push_back(cycle);
        #1 ddl_ack_i = 1'b0;
      end
    end
  end

  // DDL read stream, beats of a burst back to back
  initial begin : ddl_read_stream
    logic fire;
    int beat_n;
    int lat;
    beat_n = 0;
    lat = 2;
    ddl_rvalid_i = 1'b0;
    ddl_rlast_i = 1'b0;
    ddl_rdata_i = '0;
    forever begin
      @(posedge clock);
      fire = ddl_rvalid_i && ddl_rready_o;
      #1;
      if (fire) begin
        if (beat_n == 3) begin
          void'(burst_q.pop_front());
          beat_n = 0;
          ddl_rvalid_i = 1'b0;
          lat = 1 + int'($unsigned($random(seed)) % 3);
        end else begin
          beat_n = beat_n + 1;
        end
      end
      if (burst_q.size() != 0 && (ddl_rvalid_i || lat == 0)) begin
        ddl_rvalid_i = 1'b1;
        ddl_rdata_i = beat_data(burst_q[0].bank, burst_q[0].row, burst_q[0].col, 2'(beat_n));
        ddl_rlast_i = (beat_n == 3);
      end else begin
        ddl_rvalid_i = 1'b0;
        ddl_rlast_i = 1'b0;
        if (burst_q.size() != 0 && lat > 0) begin
          lat = lat - 1;
        end
      end
    end
  end

  // compares AXI and controller beats against the expected queues
  always @(posedge clock) begin : compare_beats
    fast_resp_s exp;
    logic [WIDTH-1:0] d;
    if (!reset && rvalid_o) begin
      assert (exp_beats.size() != 0)
        else abort_run($sformatf("FAIL %0t: AXI beat with no read outstanding", $time));
      exp = exp_beats.pop_front();
      if (rready_i) begin
        assert (resp_o.rdata == exp.rdata && resp_o.rid == exp.rid &&
                resp_o.rlast == exp.rlast && resp_o.rresp == OKAY)
          else abort_run($sformatf("FAIL %0t: beat %h id %h last %b resp %0d, want %h %h %b",
                                   $time, resp_o.rdata, resp_o.rid, resp_o.rlast,
                                   resp_o.rresp, exp.rdata, exp.rid, exp.rlast));
        if (exp.rlast) begin
          last_beat_cyc = cycle;
        end
      end else begin
        assert (resp_o.rresp == SLVERR)
          else abort_run($sformatf("FAIL %0t: dropped beat not marked SLVERR", $time));
        dropped_n = dropped_n + 1;
      end
      beats_seen = beats_seen + 1;
    end
    if (!reset && ctl_rvalid_o && ctl_rready_i) begin
      assert (exp_ctl.size() != 0)
        else abort_run($sformatf("FAIL %0t: controller beat with no read outstanding", $time));
      d = exp_ctl.pop_front();
      assert (ctl_rdata_o == d && ctl_rlast_o == (ctl_beats_seen % 4 == 3))
        else abort_run($sformatf("FAIL %0t: controller beat %h last %b, want %h",
                                 $time, ctl_rdata_o, ctl_rlast_o, d));
      ctl_beats_seen = ctl_beats_seen + 1;
    end
  end

  // one four-phase exchange on the controller port
  task automatic ctl_send(input ddr_cmd_s cmd);
    ddr_cmd_s got;
    @(posedge clock);
    #1;
    ctl_cmd_i = cmd;
    ctl_req_i = 1'b1;
    do @(posedge clock); while (!ctl_ack_o);
    ctl_ack_cyc = cycle;
    got = cmd_log[log_n-1];
    assert (got == cmd)
      else abort_run($sformatf("FAIL %0t: DDL got %h for controller command %h",
                               $time, got, cmd));
    #1 ctl_req_i = 1'b0;
    do @(posedge clock); while (ctl_ack_o);
  endtask

  // fast read, optionally with rready dropped after the first beat
  task automatic fast_read(input logic [12:0] row, input logic [2:0] bank,
                           input logic [6:0] col_hi, input logic [3:0] id, input logic drop);
    fast_req_s req;
    fast_resp_s exp;
    ddr_cmd_s got;
    ddr_cmd_s want;
    ddr_cmd_s prev;
    logic snap_open;
    logic [2:0] snap_bank;
    logic [12:0] snap_row;
    int n;
    int start;
    int first_beat;
    int gap;
    req.araddr = {row, bank, col_hi};
    req.arid = id;
    snap_open = trk_open;
    snap_bank = trk_bank;
    snap_row = trk_row;
    n = cmds_needed(snap_open, snap_bank, snap_row, req.araddr);
    start = log_n;
    first_beat = beats_seen;
    for (int i = 0; i < 4; i++) begin
      exp.rdata = beat_data(bank, row, {col_hi, 3'b000}, 2'(i));
      exp.rid = id;
      exp.rlast = (i == 3);
      exp.rresp = OKAY;
      exp_beats.push_back(exp);
    end
    @(posedge clock);
    #1;
    fast_req_i = req;
    fast_valid_i = 1'b1;
    do @(posedge clock); while (!fast_ready_o);
    accepted_n = accepted_n + 1;
    #1 fast_valid_i = 1'b0;
    if (drop) begin
      wait (beats_seen == first_beat + 1);
      #1 rready_i = 1'b0;
      @(posedge clock);
      #1 rready_i = 1'b1;
    end
    wait (beats_seen == first_beat + 4);
    wait (log_n == start + n);
    for (int k = 0; k < n; k++) begin
      got = cmd_log[start+k];
      want = expected_cmd(k, snap_open, snap_bank, snap_row, req.araddr);
      assert (got == want)
        else abort_run($sformatf("FAIL %0t: command %0d was %h, expected %h",
                                 $time, k, got, want));
      if (k > 0) begin
        prev = expected_cmd(k - 1, snap_open, snap_bank, snap_row, req.araddr);
        gap = req_cyc[start+k] - done_cyc[start+k-1];
        assert (!(prev.op == PREC && want.op == ACTV) || gap >= T_RP)
          else abort_run($sformatf("FAIL %0t: PREC to ACTV gap %0d", $time, gap));
        assert (!(prev.op == ACTV && want.op == READ) || gap >= T_RCD)
          else abort_run($sformatf("FAIL %0t: ACTV to READ gap %0d", $time, gap));
      end
    end
  endtask

  initial begin : main
    logic [12:0] row0;
    logic [12:0] row_y;
    logic [2:0] bank0;
    logic [6:0] col0;
    int acc_before;
    reset = 1'b1;
    fast_valid_i = 1'b0;
    fast_req_i = '0;
    rready_i = 1'b1;
    ctl_req_i = 1'b0;
    ctl_cmd_i = make_cmd(NOOP, 3'd0, 13'd0, 1'b0);
    ctl_rready_i = 1'b1;
    repeat (10) @(posedge clock);
    #1 reset = 1'b0;
    @(posedge clock);
    assert (!ddl_req_o && !ctl_ack_o && !fast_ready_o && !rvalid_o && !ctl_rvalid_o &&
            !fast_err_o)
      else abort_run($sformatf("FAIL %0t: outputs not idle after reset", $time));

    row0 = 13'($unsigned($random(seed)));
    row_y = 13'($unsigned($random(seed)));
    bank0 = 3'($unsigned($random(seed)));
    col0 = 7'($unsigned($random(seed)));

    // passthrough of controller commands and read data
    ctl_send(make_cmd(ACTV, bank0, row0, 1'b0));
    for (int i = 0; i < 4; i++) begin
      exp_ctl.push_back(beat_data(bank0, row0, {col0, 3'b000}, 2'(i)));
    end
    ctl_send(make_cmd(READ, bank0, {3'b000, col0, 3'b000}, 1'b0));
    wait (ctl_beats_seen == 4);

    // row hit twice
    // the second one only stays a plain READ if the row was kept open
    fast_read(row0, bank0, col0 + 7'd1, 4'($unsigned($random(seed))), 1'b0);
    fast_read(row0, bank0, col0 + 7'd2, 4'($unsigned($random(seed))), 1'b0);

    // row conflict restores the controller row
    fast_read(row0 ^ 13'h155, bank0, col0, 4'($unsigned($random(seed))), 1'b0);

    // idle bank
    fast_read(row_y, bank0 ^ 3'd1, col0, 4'($unsigned($random(seed))), 1'b0);

    // controller asks during a bypass and waits for the grant to end
    acc_before = accepted_n;
    fork
      fast_read(row_y, bank0 ^ 3'd2, col0 + 7'd3, 4'($unsigned($random(seed))), 1'b0);
      begin
        wait (accepted_n == acc_before + 1);
        repeat (2) @(posedge clock);
        ctl_send(make_cmd(ACTV, bank0 ^ 3'd3, row_y, 1'b0));
      end
    join
    assert (ctl_ack_cyc > last_beat_cyc)
      else abort_run($sformatf("FAIL %0t: controller acked before the bypass ended", $time));

    // late acceptance
    assert (!fast_err_o)
      else abort_run($sformatf("FAIL %0t: error flag set too early", $time));
    fast_read(row0, bank0 ^ 3'd4, col0, 4'($unsigned($random(seed))), 1'b1);
    assert (dropped_n > 0 && fast_err_o)
      else abort_run($sformatf("FAIL %0t: late acceptance not flagged", $time));
    repeat (5) @(posedge clock);
    assert (fast_err_o)
      else abort_run($sformatf("FAIL %0t: error flag did not stay set", $time));

    if (dut_i.chk_i.fail_n == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      abort_run($sformatf("protocol checker reported %0d assertion failures",
                          dut_i.chk_i.fail_n));
    end
  end

endmodule

`default_nettype wire

// ==== testbench/ddr3_bypass_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr3_bypass_chk (
  input wire logic clock,
  input wire logic reset,
  input wire logic grant_i,
  input wire logic ctl_req_i,
  input wire ddr3_cmd_pkg::ddr_cmd_s ctl_cmd_i,
  input wire logic ctl_ack_i,
  input wire logic ddl_req_i,
  input wire ddr3_cmd_pkg::ddr_cmd_s ddl_cmd_i,
  input wire logic ddl_ack_i
);
  import ddr3_cmd_pkg::*;

  // assertion failures so far, read by the testbench at the end
  int fail_n = 0;

  // four-phase rule, next req only once ack has fallen
  ddl_req_after_ack: assert property (@(posedge clock) disable iff (reset)
    $rose(ddl_req_i) |-> !ddl_ack_i)
    else begin
      fail_n = fail_n + 1;
      $error("DDL req rose while DDL ack was still high");
    end

  ctl_req_after_ack: assert property (@(posedge clock) disable iff (reset)
    $rose(ctl_req_i) |-> !ctl_ack_i)
    else begin
      fail_n = fail_n + 1;
      $error("controller req rose while its ack was still high");
    end

  // command held steady for the whole request phase
  ddl_cmd_stable: assert property (@(posedge clock) disable iff (reset)
    ddl_req_i && $past(ddl_req_i) |-> ddl_cmd_i == $past(ddl_cmd_i))
    else begin
      fail_n = fail_n + 1;
      $error("DDL command changed while req was high");
    end

  ctl_cmd_stable: assert property (@(posedge clock) disable iff (reset)
    ctl_req_i && $past(ctl_req_i) |-> ctl_cmd_i == $past(ctl_cmd_i))
    else begin
      fail_n = fail_n + 1;
      $error("controller command changed while req was high");
    end

  // controller held off for the grant and the cycle after it
  // an ack there could only be left over from a bypass command
  no_ack_in_grant: assert property (@(posedge clock) disable iff (reset)
    grant_i || $past(grant_i) |-> !ctl_ack_i)
    else begin
      fail_n = fail_n + 1;
      $error("controller got an ack during or right after the grant");
    end

  // grant only taken from a quiet controller port
  grant_when_quiet: assert property (@(posedge clock) disable iff (reset)
    $rose(grant_i) |-> !$past(ctl_req_i) && !$past(ctl_ack_i))
    else begin
      fail_n = fail_n + 1;
      $error("grant rose while the controller port was busy");
    end

endmodule

bind ddr3_bypass ddr3_bypass_chk chk_i (
  .clock(clock),
  .reset(reset),
  .grant_i(grant),
  .ctl_req_i(ctl_req_i),
  .ctl_cmd_i(ctl_cmd_i),
  .ctl_ack_i(ctl_ack_o),
  .ddl_req_i(ddl_req_o),
  .ddl_cmd_i(ddl_cmd_o),
  .ddl_ack_i(ddl_ack_i)
);

`default_nettype wire

// ==== verilog/ddr3_bypass.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr3_bypass #(
  parameter int WIDTH = axi_fast_pkg::FAST_WIDTH
) (
  input wire logic clock,
  input wire logic reset,
  // fast read request
  input wire logic fast_valid_i,
  input wire axi_fast_pkg::fast_req_s fast_req_i,
  output logic fast_ready_o,
  input wire logic rready_i,
  // fast read response
  output logic rvalid_o,
  output axi_fast_pkg::fast_resp_s resp_o,
  // controller command port
  input wire logic ctl_req_i,
  input wire ddr3_cmd_pkg::ddr_cmd_s ctl_cmd_i,
  output logic ctl_ack_o,
  // DDL command port
  output logic ddl_req_o,
  output ddr3_cmd_pkg::ddr_cmd_s ddl_cmd_o,
  input wire logic ddl_ack_i,
  // DDL read stream
  input wire logic ddl_rvalid_i,
  input wire logic ddl_rlast_i,
  input wire logic [WIDTH-1:0] ddl_rdata_i,
  output logic ddl_rready_o,
  // controller read stream
  output logic ctl_rvalid_o,
  output logic ctl_rlast_o,
  output logic [WIDTH-1:0] ctl_rdata_o,
  input wire logic ctl_rready_i,
  output logic fast_err_o
);
  import ddr3_cmd_pkg::*;

  logic grant;
  logic issue;
  logic restore;
  logic load;
  logic done;
  logic expired;
  logic last_beat;
  logic ctl_busy;
  logic open_hit;
  logic open_bank;
  ddr3_cmd_t op;

  bypass_fsm u_fsm (
    .clock(clock),
    .reset(reset),
    .fast_valid_i(fast_valid_i),
    .rready_i(rready_i),
    .fast_ready_o(fast_ready_o),
    .open_hit_i(open_hit),
    .open_bank_i(open_bank),
    .done_i(done),
    .expired_i(expired),
    .last_beat_i(last_beat),
    .ctl_busy_i(ctl_busy),
    .grant_o(grant),
    .issue_o(issue),
    .op_o(op),
    .restore_o(restore),
    .load_o(load)
  );

  bypass_timer u_timer (
    .clock(clock),
    .reset(reset),
    .load_i(load),
    .op_i(op),
    .expired_o(expired)
  );

  bypass_cmd_mux u_cmd_mux (
    .clock(clock),
    .reset(reset),
    .grant_i(grant),
    .issue_i(issue),
    .restore_i(restore),
    .op_i(op),
    .req_i(fast_req_i),
    .ctl_req_i(ctl_req_i),
    .ctl_cmd_i(ctl_cmd_i),
    .ctl_ack_o(ctl_ack_o),
    .ctl_busy_o(ctl_busy),
    .ddl_req_o(ddl_req_o),
    .ddl_cmd_o(ddl_cmd_o),
    .ddl_ack_i(ddl_ack_i),
    .done_o(done),
    .open_hit_o(open_hit),
    .open_bank_o(open_bank)
  );

  bypass_read_path #(
    .WIDTH(WIDTH)
  ) u_read_path (
    .clock(clock),
    .reset(reset),
    .grant_i(grant),
    .rid_i(fast_req_i.arid),
    .ddl_rvalid_i(ddl_rvalid_i),
    .ddl_rlast_i(ddl_rlast_i),
    .ddl_rdata_i(ddl_rdata_i),
    .ddl_rready_o(ddl_rready_o),
    .ctl_rvalid_o(ctl_rvalid_o),
    .ctl_rlast_o(ctl_rlast_o),
    .ctl_rdata_o(ctl_rdata_o),
    .ctl_rready_i(ctl_rready_i),
    .rready_i(rready_i),
    .rvalid_o(rvalid_o),
    .resp_o(resp_o),
    .last_beat_o(last_beat),
    .fast_err_o(fast_err_o)
  );

endmodule

`default_nettype wire

// ==== verilog/bypass_read_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module bypass_read_path #(
  parameter int WIDTH = axi_fast_pkg::FAST_WIDTH
) (
  input wire logic clock,
  input wire logic reset,
  input wire logic grant_i,
  input wire logic [axi_fast_pkg::FAST_ID_BITS-1:0] rid_i,
  input wire logic ddl_rvalid_i,
  input wire logic ddl_rlast_i,
  input wire logic [WIDTH-1:0] ddl_rdata_i,
  output logic ddl_rready_o,
  output logic ctl_rvalid_o,
  output logic ctl_rlast_o,
  output logic [WIDTH-1:0] ctl_rdata_o,
  input wire logic ctl_rready_i,
  input wire logic rready_i,
  output logic rvalid_o,
  output axi_fast_pkg::fast_resp_s resp_o,
  output logic last_beat_o,
  output logic fast_err_o
);
  import axi_fast_pkg::*;

  logic [FAST_ID_BITS-1:0] rid_q;
  logic [WIDTH-1:0] data_q;
  logic last_q;
  logic rvalid_q;
  logic err_q;
  logic take_w;

  // id of the accepted request, held for the whole grant
  always_ff @(posedge clock) begin
    if (!grant_i) begin
      rid_q <= rid_i;
    end
  end

  // stream ready comes from whoever owns the port
  assign ddl_rready_o = grant_i ? rready_i : ctl_rready_i;

  // controller beats pass only outside the grant
  assign ctl_rvalid_o = ddl_rvalid_i & ~grant_i;
  assign ctl_rlast_o = ddl_rlast_i;
  assign ctl_rdata_o = ddl_rdata_i;

  assign take_w = grant_i & ddl_rvalid_i & rready_i;

  always_ff @(posedge clock) begin
    if (take_w) begin
      data_q <= ddl_rdata_i;
      last_q <= ddl_rlast_i;
    end
  end

  // no skid buffer so a beat not taken at once is lost
  always_ff @(posedge clock) begin
    if (reset) begin
      rvalid_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      rvalid_q <= take_w;
      if (rvalid_q && !rready_i) begin
        err_q <= 1'b1;
      end
    end
  end

  assign rvalid_o = rvalid_q;
  assign fast_err_o = err_q;
  assign last_beat_o = rvalid_q & last_q;

  always_comb begin
    resp_o.rdata = data_q;
    resp_o.rid = rid_q;
    resp_o.rlast = last_q;
    // a beat offered without ready is the dropped one
    resp_o.rresp = rready_i ? OKAY : SLVERR;
  end

endmodule

`default_nettype wire

// ==== verilog/bypass_cmd_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module bypass_cmd_mux (
  input wire logic clock,
  input wire logic reset,
  input wire logic grant_i,
  input wire logic issue_i,
  input wire logic restore_i,
  input wire ddr3_cmd_pkg::ddr3_cmd_t op_i,
  input wire axi_fast_pkg::fast_req_s req_i,
  input wire logic ctl_req_i,
  input wire ddr3_cmd_pkg::ddr_cmd_s ctl_cmd_i,
  output logic ctl_ack_o,
  output logic ctl_busy_o,
  output logic ddl_req_o,
  output ddr3_cmd_pkg::ddr_cmd_s ddl_cmd_o,
  input wire logic ddl_ack_i,
  output logic done_o,
  output logic open_hit_o,
  output logic open_bank_o
);
  import ddr3_cmd_pkg::*;
  import axi_fast_pkg::*;

  localparam int COL_HI = FAST_ADDRS - ROW_BITS - BANK_BITS;
  localparam int COL_LO = COL_BITS - COL_HI;

  logic [FAST_ADDRS-1:0] addr_q;
  logic [ROW_BITS-1:0] row_w;
  logic [BANK_BITS-1:0] bank_w;
  logic [COL_HI-1:0] col_hi_w;
  logic [COL_BITS-1:0] col_w;
  logic [ROW_BITS-1:0] save_row_q;
  logic open_q;
  logic [BANK_BITS-1:0] open_bank_q;
  logic [ROW_BITS-1:0] open_row_q;
  logic req_q;
  logic busy_q;
  logic issued_q;
  logic fire_w;
  ddr_cmd_s cmd_w;
  ddr_cmd_s cmd_q;

  // capture the request until the grant rises
  // the cycle of acceptance is the last one without grant
  always_ff @(posedge clock) begin
    if (!grant_i) begin
      addr_q <= req_i.araddr;
      save_row_q <= open_row_q;
    end
  end

  assign {row_w, bank_w, col_hi_w} = addr_q;
  // burst aligned column
  assign col_w = {col_hi_w, {COL_LO{1'b0}}};

  always_comb begin
    cmd_w.op = op_i;
    cmd_w.bank = bank_w;
    cmd_w.auto_pre = 1'b0;
    case (op_i)
      ACTV: cmd_w.addr = restore_i ? save_row_q : row_w;
      READ: begin
        cmd_w.addr = {{(ROW_BITS - COL_BITS){1'b0}}, col_w};
        // only a hit as the first command keeps the row open
        cmd_w.auto_pre = ~open_hit_o | issued_q;
      end
      default: cmd_w.addr = '0;
    endcase
  end

  // four-phase exchange on the DDL side
  assign done_o = busy_q & ~req_q & ~ddl_ack_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      req_q <= 1'b0;
      busy_q <= 1'b0;
    end else if (issue_i) begin
      req_q <= 1'b1;
      busy_q <= 1'b1;
    end else if (req_q && ddl_ack_i) begin
      req_q <= 1'b0;
    end else if (done_o) begin
      busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (issue_i) begin
      cmd_q <= cmd_w;
    end
  end

  // any command already sent under this grant
  always_ff @(posedge clock) begin
    if (reset) begin
      issued_q <= 1'b0;
    end else if (!grant_i) begin
      issued_q <= 1'b0;
    end else if (issue_i) begin
      issued_q <= 1'b1;
    end
  end

  // controller sees no ack while the port is taken
  assign ddl_req_o = grant_i ? req_q : ctl_req_i;
  assign ddl_cmd_o = grant_i ? cmd_q : ctl_cmd_i;
  assign ctl_ack_o = ~grant_i & ddl_ack_i;
  assign ctl_busy_o = ctl_req_i | ctl_ack_o;

  // open row tracker, fed by both sources
  assign fire_w = ddl_req_o & ddl_ack_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      open_q <= 1'b0;
    end else if (fire_w) begin
      case (ddl_cmd_o.op)
        ACTV: open_q <= 1'b1;
        PREC: open_q <= 1'b0;
        READ: open_q <= open_q & ~ddl_cmd_o.auto_pre;
        default: open_q <= open_q;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (fire_w && ddl_cmd_o.op == ACTV) begin
      open_bank_q <= ddl_cmd_o.bank;
      open_row_q <= ddl_cmd_o.addr;
    end
  end

  assign open_hit_o = open_q & (open_bank_q == bank_w) & (open_row_q == row_w);
  assign open_bank_o = open_q & (open_bank_q == bank_w) & (open_row_q != row_w);

endmodule

`default_nettype wire

// ==== verilog/bypass_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module bypass_fsm (
  input wire logic clock,
  input wire logic reset,
  input wire logic fast_valid_i,
  input wire logic rready_i,
  output logic fast_ready_o,
  input wire logic open_hit_i,
  input wire logic open_bank_i,
  input wire logic done_i,
  input wire logic expired_i,
  input wire logic last_beat_i,
  input wire logic ctl_busy_i,
  output logic grant_o,
  output logic issue_o,
  output ddr3_cmd_pkg::ddr3_cmd_t op_o,
  output logic restore_o,
  output logic load_o
);
  import ddr3_cmd_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    WAIT_CTL,
    PRE,
    ACT,
    RD,
    DRAIN,
    RESTORE
  } state_t;

  state_t state_q;
  state_t first_st;
  ddr3_cmd_t first_op;
  logic grant_q;
  // command of the current state already handed to the mux
  logic sent_q;
  // controller row must be re-opened after the read
  logic conflict_q;
  // last AXI beat already presented
  logic last_q;
  logic cmd_state;
  logic accept;
  logic finish;

  // both arvalid and rready needed, and the controller port quiet
  assign accept = (state_q == IDLE) & fast_valid_i & rready_i & ~ctl_busy_i;
  assign fast_ready_o = accept;
  assign grant_o = grant_q;
  assign finish = last_q | last_beat_i;

  assign cmd_state = (state_q == PRE) | (state_q == ACT) | (state_q == RD) |
                     (state_q == RESTORE);

  // path choice from the tracker
  always_comb begin
    if (open_bank_i) begin
      first_st = PRE;
      first_op = PREC;
    end else if (open_hit_i) begin
      first_st = RD;
      first_op = READ;
    end else begin
      first_st = ACT;
      first_op = ACTV;
    end
  end

  always_comb begin
    case (state_q)
      WAIT_CTL: op_o = first_op;
      PRE: op_o = PREC;
      ACT, RESTORE: op_o = ACTV;
      RD: op_o = READ;
      default: op_o = NOOP;
    endcase
  end

  // first command leaves straight from WAIT_CTL
  assign issue_o = expired_i & ((state_q == WAIT_CTL) | (cmd_state & ~sent_q));
  assign load_o = cmd_state & done_i;
  assign restore_o = (state_q == RESTORE);

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= IDLE;
      grant_q <= 1'b0;
      sent_q <= 1'b0;
      conflict_q <= 1'b0;
      last_q <= 1'b0;
    end else begin
      if (last_beat_i) begin
        last_q <= 1'b1;
      end
      if (issue_o) begin
        sent_q <= 1'b1;
      end
      if (load_o) begin
        sent_q <= 1'b0;
      end
      case (state_q)
        IDLE: begin
          if (accept) begin
            state_q <= WAIT_CTL;
            grant_q <= 1'b1;
            last_q <= 1'b0;
          end
        end
        WAIT_CTL: begin
          if (expired_i) begin
            state_q <= first_st;
            conflict_q <= open_bank_i;
          end
        end
        PRE: begin
          if (done_i) begin
            state_q <= ACT;
          end
        end
        ACT: begin
          if (done_i) begin
            state_q <= RD;
          end
        end
        RD, RESTORE: begin
          // restore may overlap the returning burst
          if (done_i) begin
            if (state_q == RD && conflict_q) begin
              state_q <= RESTORE;
            end else if (finish) begin
              state_q <= IDLE;
              grant_q <= 1'b0;
            end else begin
              state_q <= DRAIN;
            end
          end
        end
        DRAIN: begin
          if (finish) begin
            state_q <= IDLE;
            grant_q <= 1'b0;
          end
        end
        default: begin
          state_q <= IDLE;
          grant_q <= 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/bypass_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddr3_timing.svh"

module bypass_timer (
  input wire logic clock,
  input wire logic reset,
  input wire logic load_i,
  input wire ddr3_cmd_pkg::ddr3_cmd_t op_i,
  output logic expired_o
);
  import ddr3_cmd_pkg::*;

  // counter sized for the longest wait
  localparam int T_MAX = (`T_RP > `T_RCD) ? `T_RP : `T_RCD;
  localparam int CNT_BITS = $clog2(T_MAX + 1);

  logic [CNT_BITS-1:0] count_q;

  // load on the completion of each bypass command
  always_ff @(posedge clock) begin
    if (reset) begin
      count_q <= '0;
    end else if (load_i) begin
      case (op_i)
        PREC: count_q <= CNT_BITS'(`T_RP);
        ACTV: count_q <= CNT_BITS'(`T_RCD);
        default: count_q <= CNT_BITS'(`T_RD);
      endcase
    end else if (count_q != '0) begin
      count_q <= count_q - 1'b1;
    end
  end

  // next command may go once the count is spent
  assign expired_o = (count_q == '0);

endmodule

`default_nettype wire

// ==== verilog/axi_fast_pkg.sv ====
`default_nettype none

package axi_fast_pkg;

  // burst aligned address {row, bank, column[9:3]}
  localparam int FAST_ADDRS = 23;
  localparam int FAST_ID_BITS = 4;
  // width of one returned beat
  localparam int FAST_WIDTH = 32;

  // AXI response codes
  typedef enum logic [1:0] {
    OKAY = 2'b00,
    SLVERR = 2'b10
  } fast_resp_t;

  // read address channel
  typedef struct packed {
    logic [FAST_ADDRS-1:0] araddr;
    logic [FAST_ID_BITS-1:0] arid;
  } fast_req_s;

  // read data channel
  typedef struct packed {
    logic [FAST_WIDTH-1:0] rdata;
    logic [FAST_ID_BITS-1:0] rid;
    logic rlast;
    fast_resp_t rresp;
  } fast_resp_s;

endpackage

`default_nettype wire

// ==== verilog/ddr3_cmd_pkg.sv ====
`default_nettype none

package ddr3_cmd_pkg;

  // geometry of a 1Gb x16 device
  localparam int ROW_BITS = 13;
  localparam int COL_BITS = 10;
  localparam int BANK_BITS = 3;

  // opcodes use the {ras_n, cas_n, we_n} pin pattern
  typedef enum logic [2:0] {
    NOOP = 3'b111,
    PREC = 3'b010,
    ACTV = 3'b011,
    READ = 3'b101,
    REFR = 3'b001
  } ddr3_cmd_t;

  // one command on a DDL command port
  // addr holds the row for ACTV and the column for READ
  typedef struct packed {
    ddr3_cmd_t op;
    logic [BANK_BITS-1:0] bank;
    logic [ROW_BITS-1:0] addr;
    logic auto_pre;
  } ddr_cmd_s;

endpackage

`default_nettype wire

// ==== include/ddr3_timing.svh ====
`ifndef DDR3_TIMING_SVH
`define DDR3_TIMING_SVH

// DDR3 command spacing in controller clock cycles
// values suit a 100 MHz controller clock

// precharge to activate in the same bank
`define T_RP 4

// activate to read or write in the same bank
`define T_RCD 4

// a READ places no constraint on the command that follows it here
`define T_RD 0

`endif
